// File: design/axi_rd_pkg.sv
/* Read channel payload types, AXI response codes and the address map rule */
package axi_rd_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Encodings follow the AXI RRESP field
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // One address window; end_addr is exclusive
  typedef struct packed {
    logic [xbar_cfg_pkg::MST_IDX_W-1:0] idx;
    addr_t                              start_addr;
    addr_t                              end_addr;
  } rule_t;

endpackage

// File: design/rd_addr_decode.sv
/* Read address decoder: maps an address onto a master index through the rule
   table, with an optional default port and the error target as fallback */
`timescale 1ns/100ps

module rd_addr_decode (
  input  axi_rd_pkg::addr_t                                   addr_i,
  input  axi_rd_pkg::rule_t [xbar_cfg_pkg::NO_ADDR_RULES-1:0] addr_map_i,
  input  logic                                                en_default_i,
  input  logic [xbar_cfg_pkg::MST_IDX_W-1:0]                  default_idx_i,
  output logic [xbar_cfg_pkg::SEL_W-1:0]                      sel_o
);

  import xbar_cfg_pkg::*;
  import axi_rd_pkg::*;

  logic [NO_ADDR_RULES-1:0] rule_hit;

  // Window compare for every rule in parallel
  always_comb begin
    for (int r = 0; r < NO_ADDR_RULES; r++) begin
      rule_hit[r] = (addr_i >= addr_map_i[r].start_addr) &&
                    (addr_i < addr_map_i[r].end_addr);
    end
  end

  // Fallback first, then rules from the highest number down so that the
  // lowest matching rule is the one left standing
  always_comb begin
    if (en_default_i) begin
      sel_o = SEL_W'(default_idx_i);
    end else begin
      sel_o = SEL_W'(NO_MST_PORTS);
    end
    for (int r = NO_ADDR_RULES - 1; r >= 0; r--) begin
      if (rule_hit[r]) begin
        sel_o = SEL_W'(addr_map_i[r].idx);
      end
    end
  end

endmodule

// File: design/rd_demux.sv
/* Read demultiplexer for one slave port: steers AR to the selected target and
   keeps R in order by locking onto one target while reads are in flight */
`timescale 1ns/100ps

module rd_demux (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  // Slave side
  input  logic                                             slv_ar_valid_i,
  input  axi_rd_pkg::addr_t                                slv_ar_addr_i,
  input  logic [xbar_cfg_pkg::SEL_W-1:0]                   sel_i,
  output logic                                             slv_ar_ready_o,
  output logic                                             slv_r_valid_o,
  output axi_rd_pkg::data_t                                slv_r_data_o,
  output axi_rd_pkg::resp_e                                slv_r_resp_o,
  input  logic                                             slv_r_ready_i,
  // Target side, the last index is the error target
  output logic              [xbar_cfg_pkg::NO_MST_PORTS:0] tgt_ar_valid_o,
  output axi_rd_pkg::addr_t [xbar_cfg_pkg::NO_MST_PORTS:0] tgt_ar_addr_o,
  input  logic              [xbar_cfg_pkg::NO_MST_PORTS:0] tgt_ar_ready_i,
  input  logic              [xbar_cfg_pkg::NO_MST_PORTS:0] tgt_r_valid_i,
  input  axi_rd_pkg::data_t [xbar_cfg_pkg::NO_MST_PORTS:0] tgt_r_data_i,
  input  axi_rd_pkg::resp_e [xbar_cfg_pkg::NO_MST_PORTS:0] tgt_r_resp_i,
  output logic              [xbar_cfg_pkg::NO_MST_PORTS:0] tgt_r_ready_o
);

  import xbar_cfg_pkg::*;
  import axi_rd_pkg::*;

  logic [CNT_W-1:0] cnt_q;
  logic [SEL_W-1:0] lock_q;
  logic             busy;
  logic             ar_ok;
  logic             ar_fire;
  logic             r_fire;

  assign busy = (cnt_q != '0);

  // A new read may only go to the target that still owes responses
  assign ar_ok = (cnt_q < CNT_W'(MAX_TRANS)) && (!busy || (sel_i == lock_q));

  always_comb begin
    for (int t = 0; t <= NO_MST_PORTS; t++) begin
      tgt_ar_valid_o[t] = slv_ar_valid_i && ar_ok && (sel_i == SEL_W'(t));
      tgt_ar_addr_o[t]  = slv_ar_addr_i;
    end
  end

  assign slv_ar_ready_o = ar_ok && tgt_ar_ready_i[sel_i];
  assign ar_fire        = slv_ar_valid_i && slv_ar_ready_o;

  // Responses only from the locked target
  assign slv_r_valid_o = busy && tgt_r_valid_i[lock_q];
  assign slv_r_data_o  = tgt_r_data_i[lock_q];
  assign slv_r_resp_o  = tgt_r_resp_i[lock_q];
  assign r_fire        = slv_r_valid_o && slv_r_ready_i;

  always_comb begin
    for (int t = 0; t <= NO_MST_PORTS; t++) begin
      tgt_r_ready_o[t] = busy && slv_r_ready_i && (lock_q == SEL_W'(t));
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      lock_q <= '0;
    end else begin
      cnt_q <= cnt_q + CNT_W'(ar_fire) - CNT_W'(r_fire);
      if (ar_fire) begin
        lock_q <= sel_i;
      end
    end
  end

endmodule

// File: design/rd_err_slv.sv
/* Decode-error slave: counts accepted reads and answers each one with a
   single DECERR beat carrying zero data */
`timescale 1ns/100ps

module rd_err_slv (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  output logic              r_valid_o,
  output axi_rd_pkg::data_t r_data_o,
  output axi_rd_pkg::resp_e r_resp_o,
  input  logic              r_ready_i
);

  import xbar_cfg_pkg::*;
  import axi_rd_pkg::*;

  // Reads carry no payload here, so the FIFO reduces to its fill count
  logic [CNT_W-1:0] fill_q;
  logic             ar_fire;
  logic             r_fire;

  assign ar_ready_o = (fill_q < CNT_W'(MAX_TRANS));
  assign ar_fire    = ar_valid_i && ar_ready_o;

  assign r_valid_o = (fill_q != '0);
  assign r_data_o  = '0;
  assign r_resp_o  = RESP_DECERR;
  assign r_fire    = r_valid_o && r_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fill_q <= '0;
    end else begin
      fill_q <= fill_q + CNT_W'(ar_fire) - CNT_W'(r_fire);
    end
  end

endmodule

// File: design/rd_reg_slice.sv
/* Register slice for one crossbar connection: a two-entry skid buffer on AR
   and on R, so no combinational path crosses it */
`timescale 1ns/100ps

module rd_reg_slice (
  input  logic              clk_i,
  input  logic              rst_i,
  // Slave side
  input  logic              s_ar_valid_i,
  input  axi_rd_pkg::addr_t s_ar_addr_i,
  output logic              s_ar_ready_o,
  output logic              s_r_valid_o,
  output axi_rd_pkg::data_t s_r_data_o,
  output axi_rd_pkg::resp_e s_r_resp_o,
  input  logic              s_r_ready_i,
  // Master side
  output logic              m_ar_valid_o,
  output axi_rd_pkg::addr_t m_ar_addr_o,
  input  logic              m_ar_ready_i,
  input  logic              m_r_valid_i,
  input  axi_rd_pkg::data_t m_r_data_i,
  input  axi_rd_pkg::resp_e m_r_resp_i,
  output logic              m_r_ready_o
);

  import axi_rd_pkg::*;

  localparam int RESP_W = $bits(resp_e);
  localparam int PLD_W  = ((ADDR_W > DATA_W) ? ADDR_W : DATA_W) + RESP_W;

  // Channel 0 is AR (slave to master), channel 1 is R (master to slave)
  logic [1:0]             in_valid;
  logic [1:0]             in_ready;
  logic [1:0][PLD_W-1:0]  in_pld;
  logic [1:0]             out_valid;
  logic [1:0]             out_ready;
  logic [1:0][PLD_W-1:0]  out_pld;

  assign in_valid[0]  = s_ar_valid_i;
  assign in_pld[0]    = PLD_W'(s_ar_addr_i);
  assign s_ar_ready_o = in_ready[0];
  assign m_ar_valid_o = out_valid[0];
  assign m_ar_addr_o  = out_pld[0][ADDR_W-1:0];
  assign out_ready[0] = m_ar_ready_i;

  assign in_valid[1]  = m_r_valid_i;
  assign in_pld[1]    = PLD_W'({m_r_resp_i, m_r_data_i});
  assign m_r_ready_o  = in_ready[1];
  assign s_r_valid_o  = out_valid[1];
  assign s_r_data_o   = out_pld[1][DATA_W-1:0];
  assign s_r_resp_o   = resp_e'(out_pld[1][DATA_W +: RESP_W]);
  assign out_ready[1] = s_r_ready_i;

  for (genvar c = 0; c < 2; c++) begin : gen_chan
    logic             head_vld_q;
    logic             skid_vld_q;
    logic [PLD_W-1:0] head_q;
    logic [PLD_W-1:0] skid_q;
    logic             push;
    logic             pop;
    logic             load_head;
    logic             load_skid;

    // Ready only looks at our own fill
    assign in_ready[c]  = !skid_vld_q;
    assign out_valid[c] = head_vld_q;
    assign out_pld[c]   = head_q;

    assign push      = in_valid[c] && in_ready[c];
    assign pop       = head_vld_q && out_ready[c];
    assign load_head = (pop && (skid_vld_q || push)) || (push && !head_vld_q);
    assign load_skid = push && head_vld_q && !pop;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        head_vld_q <= 1'b0;
        skid_vld_q <= 1'b0;
      end else begin
        head_vld_q <= head_vld_q ? (!pop || skid_vld_q || push) : push;
        skid_vld_q <= skid_vld_q ? !pop : load_skid;
      end
    end

    // Head refills from the skid entry first to keep order
    always_ff @(posedge clk_i) begin
      if (load_head) begin
        head_q <= skid_vld_q ? skid_q : in_pld[c];
      end
      if (load_skid) begin
        skid_q <= in_pld[c];
      end
    end
  end

endmodule

// File: design/rd_xbar_unmuxed.sv
/* Read-only unmuxed crossbar: per slave port decoder, demux and error slave,
   and one register slice for every connected slave/master pair */
`timescale 1ns/100ps

module rd_xbar_unmuxed (
  input  logic                                                clk_i,
  input  logic                                                rst_i,
  // Slave ports
  input  logic              [xbar_cfg_pkg::NO_SLV_PORTS-1:0]  slv_ar_valid_i,
  input  axi_rd_pkg::addr_t [xbar_cfg_pkg::NO_SLV_PORTS-1:0]  slv_ar_addr_i,
  output logic              [xbar_cfg_pkg::NO_SLV_PORTS-1:0]  slv_ar_ready_o,
  output logic              [xbar_cfg_pkg::NO_SLV_PORTS-1:0]  slv_r_valid_o,
  output axi_rd_pkg::data_t [xbar_cfg_pkg::NO_SLV_PORTS-1:0]  slv_r_data_o,
  output axi_rd_pkg::resp_e [xbar_cfg_pkg::NO_SLV_PORTS-1:0]  slv_r_resp_o,
  input  logic              [xbar_cfg_pkg::NO_SLV_PORTS-1:0]  slv_r_ready_i,
  // Master ports, one channel per slave port, indexed [master][slave]
  output logic [xbar_cfg_pkg::NO_MST_PORTS-1:0][xbar_cfg_pkg::NO_SLV_PORTS-1:0]
    mst_ar_valid_o,
  output axi_rd_pkg::addr_t [xbar_cfg_pkg::NO_MST_PORTS-1:0][xbar_cfg_pkg::NO_SLV_PORTS-1:0]
    mst_ar_addr_o,
  input  logic [xbar_cfg_pkg::NO_MST_PORTS-1:0][xbar_cfg_pkg::NO_SLV_PORTS-1:0]
    mst_ar_ready_i,
  input  logic [xbar_cfg_pkg::NO_MST_PORTS-1:0][xbar_cfg_pkg::NO_SLV_PORTS-1:0]
    mst_r_valid_i,
  input  axi_rd_pkg::data_t [xbar_cfg_pkg::NO_MST_PORTS-1:0][xbar_cfg_pkg::NO_SLV_PORTS-1:0]
    mst_r_data_i,
  input  axi_rd_pkg::resp_e [xbar_cfg_pkg::NO_MST_PORTS-1:0][xbar_cfg_pkg::NO_SLV_PORTS-1:0]
    mst_r_resp_i,
  output logic [xbar_cfg_pkg::NO_MST_PORTS-1:0][xbar_cfg_pkg::NO_SLV_PORTS-1:0]
    mst_r_ready_o,
  // Address map and default routing, quasi-static
  input  axi_rd_pkg::rule_t [xbar_cfg_pkg::NO_ADDR_RULES-1:0] addr_map_i,
  input  logic [xbar_cfg_pkg::NO_SLV_PORTS-1:0]               en_default_mst_port_i,
  input  logic [xbar_cfg_pkg::NO_SLV_PORTS-1:0][xbar_cfg_pkg::MST_IDX_W-1:0]
    default_mst_port_i
);

  import xbar_cfg_pkg::*;
  import axi_rd_pkg::*;

  // Demux target channels, one extra index per slave port for the error slave
  logic  [NO_SLV_PORTS-1:0][NO_MST_PORTS:0] dmx_ar_valid;
  addr_t [NO_SLV_PORTS-1:0][NO_MST_PORTS:0] dmx_ar_addr;
  logic  [NO_SLV_PORTS-1:0][NO_MST_PORTS:0] dmx_ar_ready;
  logic  [NO_SLV_PORTS-1:0][NO_MST_PORTS:0] dmx_r_valid;
  data_t [NO_SLV_PORTS-1:0][NO_MST_PORTS:0] dmx_r_data;
  resp_e [NO_SLV_PORTS-1:0][NO_MST_PORTS:0] dmx_r_resp;
  logic  [NO_SLV_PORTS-1:0][NO_MST_PORTS:0] dmx_r_ready;

  for (genvar i = 0; i < NO_SLV_PORTS; i++) begin : gen_slv_port
    logic [SEL_W-1:0] ar_sel;

    rd_addr_decode i_decode (
      .addr_i        (slv_ar_addr_i[i]),
      .addr_map_i    (addr_map_i),
      .en_default_i  (en_default_mst_port_i[i]),
      .default_idx_i (default_mst_port_i[i]),
      .sel_o         (ar_sel)
    );

    rd_demux i_demux (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .slv_ar_valid_i (slv_ar_valid_i[i]),
      .slv_ar_addr_i  (slv_ar_addr_i[i]),
      .sel_i          (ar_sel),
      .slv_ar_ready_o (slv_ar_ready_o[i]),
      .slv_r_valid_o  (slv_r_valid_o[i]),
      .slv_r_data_o   (slv_r_data_o[i]),
      .slv_r_resp_o   (slv_r_resp_o[i]),
      .slv_r_ready_i  (slv_r_ready_i[i]),
      .tgt_ar_valid_o (dmx_ar_valid[i]),
      .tgt_ar_addr_o  (dmx_ar_addr[i]),
      .tgt_ar_ready_i (dmx_ar_ready[i]),
      .tgt_r_valid_i  (dmx_r_valid[i]),
      .tgt_r_data_i   (dmx_r_data[i]),
      .tgt_r_resp_i   (dmx_r_resp[i]),
      .tgt_r_ready_o  (dmx_r_ready[i])
    );

    // Unmapped reads end here
    rd_err_slv i_err_slv (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .ar_valid_i (dmx_ar_valid[i][NO_MST_PORTS]),
      .ar_ready_o (dmx_ar_ready[i][NO_MST_PORTS]),
      .r_valid_o  (dmx_r_valid[i][NO_MST_PORTS]),
      .r_data_o   (dmx_r_data[i][NO_MST_PORTS]),
      .r_resp_o   (dmx_r_resp[i][NO_MST_PORTS]),
      .r_ready_i  (dmx_r_ready[i][NO_MST_PORTS])
    );
  end

  for (genvar i = 0; i < NO_SLV_PORTS; i++) begin : gen_slv_cross
    for (genvar j = 0; j < NO_MST_PORTS; j++) begin : gen_mst_cross
      if (CONNECTIVITY[i][j]) begin : gen_connection
        rd_reg_slice i_slice (
          .clk_i        (clk_i),
          .rst_i        (rst_i),
          .s_ar_valid_i (dmx_ar_valid[i][j]),
          .s_ar_addr_i  (dmx_ar_addr[i][j]),
          .s_ar_ready_o (dmx_ar_ready[i][j]),
          .s_r_valid_o  (dmx_r_valid[i][j]),
          .s_r_data_o   (dmx_r_data[i][j]),
          .s_r_resp_o   (dmx_r_resp[i][j]),
          .s_r_ready_i  (dmx_r_ready[i][j]),
          .m_ar_valid_o (mst_ar_valid_o[j][i]),
          .m_ar_addr_o  (mst_ar_addr_o[j][i]),
          .m_ar_ready_i (mst_ar_ready_i[j][i]),
          .m_r_valid_i  (mst_r_valid_i[j][i]),
          .m_r_data_i   (mst_r_data_i[j][i]),
          .m_r_resp_i   (mst_r_resp_i[j][i]),
          .m_r_ready_o  (mst_r_ready_o[j][i])
        );
      end else begin : gen_no_connection
        // Master channel stays idle, reads to it get DECERR
        assign mst_ar_valid_o[j][i] = 1'b0;
        assign mst_ar_addr_o[j][i]  = '0;
        assign mst_r_ready_o[j][i]  = 1'b0;

        rd_err_slv i_err_slv (
          .clk_i      (clk_i),
          .rst_i      (rst_i),
          .ar_valid_i (dmx_ar_valid[i][j]),
          .ar_ready_o (dmx_ar_ready[i][j]),
          .r_valid_o  (dmx_r_valid[i][j]),
          .r_data_o   (dmx_r_data[i][j]),
          .r_resp_o   (dmx_r_resp[i][j]),
          .r_ready_i  (dmx_r_ready[i][j])
        );
      end
    end
  end

endmodule

// File: design/xbar_cfg_pkg.sv
/* Crossbar configuration: port counts, index widths, the outstanding read
   limit and the slave-to-master connectivity matrix */
package xbar_cfg_pkg;

  localparam int NO_SLV_PORTS  = 2;
  localparam int NO_MST_PORTS  = 2;
  localparam int NO_ADDR_RULES = 3;

  // Master index, and the demux select that also reaches the error target
  localparam int MST_IDX_W = 1;
  localparam int SEL_W     = 2;

  // Outstanding reads per slave port, also the depth of each error slave
  localparam int MAX_TRANS = 4;
  localparam int CNT_W     = 3;

  // Indexed [slave][master]
  // slave 1 has no path to master 0
  localparam bit [NO_SLV_PORTS-1:0][NO_MST_PORTS-1:0] CONNECTIVITY = {
    2'b10,
    2'b11
  };

endpackage

// File: rd_xbar_unmuxed.f
design/xbar_cfg_pkg.sv
design/axi_rd_pkg.sv
design/rd_addr_decode.sv
design/rd_demux.sv
design/rd_err_slv.sv
design/rd_reg_slice.sv
design/rd_xbar_unmuxed.sv
verif/rd_xbar_sva.sv
verif/rd_xbar_tb.sv

// File: verif/rd_xbar_sva.sv
/* Protocol checks bound to the crossbar top level: handshake stability,
   the unconnected master channel and responses without a pending read */
`timescale 1ns/100ps

module rd_xbar_sva (
  input logic                                                               clk_i,
  input logic                                                               rst_i,
  input logic [xbar_cfg_pkg::NO_SLV_PORTS-1:0]                              slv_ar_valid_i,
  input logic [xbar_cfg_pkg::NO_SLV_PORTS-1:0]                              slv_ar_ready_o,
  input logic [xbar_cfg_pkg::NO_SLV_PORTS-1:0]                              slv_r_valid_o,
  input axi_rd_pkg::data_t [xbar_cfg_pkg::NO_SLV_PORTS-1:0]                 slv_r_data_o,
  input axi_rd_pkg::resp_e [xbar_cfg_pkg::NO_SLV_PORTS-1:0]                 slv_r_resp_o,
  input logic [xbar_cfg_pkg::NO_SLV_PORTS-1:0]                              slv_r_ready_i,
  input logic [xbar_cfg_pkg::NO_MST_PORTS-1:0][xbar_cfg_pkg::NO_SLV_PORTS-1:0] mst_ar_valid_o,
  input axi_rd_pkg::addr_t [xbar_cfg_pkg::NO_MST_PORTS-1:0][xbar_cfg_pkg::NO_SLV_PORTS-1:0]
    mst_ar_addr_o,
  input logic [xbar_cfg_pkg::NO_MST_PORTS-1:0][xbar_cfg_pkg::NO_SLV_PORTS-1:0] mst_ar_ready_i
);

  import xbar_cfg_pkg::*;
  import axi_rd_pkg::*;

  int                                 fail_cnt = 0;
  logic [NO_SLV_PORTS-1:0][CNT_W-1:0] pend_q;

  // Reads accepted on a slave port and not yet answered
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= '0;
    end else begin
      for (int i = 0; i < NO_SLV_PORTS; i++) begin
        pend_q[i] <= pend_q[i] + CNT_W'(slv_ar_valid_i[i] && slv_ar_ready_o[i])
                               - CNT_W'(slv_r_valid_o[i] && slv_r_ready_i[i]);
      end
    end
  end

  for (genvar i = 0; i < NO_SLV_PORTS; i++) begin : gen_slv
    r_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      slv_r_valid_o[i] && !slv_r_ready_i[i] |=>
        slv_r_valid_o[i] && $stable(slv_r_data_o[i]) && $stable(slv_r_resp_o[i]))
      else begin
        $error("slave port %0d dropped or changed R before ready", i);
        fail_cnt++;
      end

    r_pending: assert property (@(posedge clk_i) disable iff (rst_i)
      slv_r_valid_o[i] |-> (pend_q[i] != '0))
      else begin
        $error("slave port %0d shows R with no read outstanding", i);
        fail_cnt++;
      end
  end

  for (genvar j = 0; j < NO_MST_PORTS; j++) begin : gen_mst
    for (genvar i = 0; i < NO_SLV_PORTS; i++) begin : gen_pair
      ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        mst_ar_valid_o[j][i] && !mst_ar_ready_i[j][i] |=>
          mst_ar_valid_o[j][i] && $stable(mst_ar_addr_o[j][i]))
        else begin
          $error("master %0d channel %0d dropped or changed AR before ready", j, i);
          fail_cnt++;
        end
    end
  end

  // Slave 1 has no connection to master 0
  ar_unconnected: assert property (@(posedge clk_i) disable iff (rst_i)
    !mst_ar_valid_o[0][1])
    else begin
      $error("AR raised on unconnected master 0 channel 1");
      fail_cnt++;
    end

endmodule

bind rd_xbar_unmuxed rd_xbar_sva i_sva (.*);

// File: verif/rd_xbar_tb.sv
/* Testbench for the read-only unmuxed crossbar: drives both slave ports,
   models every master channel and checks each read response in order */
`timescale 1ns/100ps

module rd_xbar_tb;

  import xbar_cfg_pkg::*;
  import axi_rd_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;

  logic                                               clk_i = 1'b0;
  logic                                               rst_i;
  logic  [NO_SLV_PORTS-1:0]                           slv_ar_valid_i;
  addr_t [NO_SLV_PORTS-1:0]                           slv_ar_addr_i;
  logic  [NO_SLV_PORTS-1:0]                           slv_ar_ready_o;
  logic  [NO_SLV_PORTS-1:0]                           slv_r_valid_o;
  data_t [NO_SLV_PORTS-1:0]                           slv_r_data_o;
  resp_e [NO_SLV_PORTS-1:0]                           slv_r_resp_o;
  logic  [NO_SLV_PORTS-1:0]                           slv_r_ready_i;
  logic  [NO_MST_PORTS-1:0][NO_SLV_PORTS-1:0]         mst_ar_valid_o;
  addr_t [NO_MST_PORTS-1:0][NO_SLV_PORTS-1:0]         mst_ar_addr_o;
  logic  [NO_MST_PORTS-1:0][NO_SLV_PORTS-1:0]         mst_ar_ready_i;
  logic  [NO_MST_PORTS-1:0][NO_SLV_PORTS-1:0]         mst_r_valid_i;
  data_t [NO_MST_PORTS-1:0][NO_SLV_PORTS-1:0]         mst_r_data_i;
  resp_e [NO_MST_PORTS-1:0][NO_SLV_PORTS-1:0]         mst_r_resp_i;
  logic  [NO_MST_PORTS-1:0][NO_SLV_PORTS-1:0]         mst_r_ready_o;
  rule_t [NO_ADDR_RULES-1:0]                          addr_map_i;
  logic  [NO_SLV_PORTS-1:0]                           en_default_mst_port_i;
  logic  [NO_SLV_PORTS-1:0][MST_IDX_W-1:0]            default_mst_port_i;

  // Pending requests, expected {resp, data} beats and master-side read queues
  addr_t             req_q [NO_SLV_PORTS][$];
  logic [DATA_W+1:0] exp_q [NO_SLV_PORTS][$];
  addr_t             mst_q [NO_MST_PORTS][NO_SLV_PORTS][$];
  bit                back_pressure = 1'b0;
  bit                aborted = 1'b0;
  int                errors = 0;
  int                tests_run = 0;
  int                tests_failed = 0;

  rd_xbar_unmuxed uut (.*);

  always #2 clk_i = ~clk_i;

  // Reference decode: first matching window, then default port, else DECERR
  function automatic logic [DATA_W+1:0] expect_beat(input int slv, input addr_t addr);
    int tgt;
    tgt = -1;
    for (int r = 0; r < NO_ADDR_RULES; r++) begin
      if (tgt < 0 && addr >= addr_map_i[r].start_addr && addr < addr_map_i[r].end_addr) begin
        tgt = int'(addr_map_i[r].idx);
      end
    end
    if (tgt < 0 && en_default_mst_port_i[slv]) begin
      tgt = int'(default_mst_port_i[slv]);
    end
    // Slave 1 has no path to master 0
    if (tgt < 0 || (slv == 1 && tgt == 0)) begin
      return {RESP_DECERR, 32'h0};
    end
    return {RESP_OKAY, (addr ^ 32'hA5A5_0000) + DATA_W'(tgt)};
  endfunction

  function automatic int total_errors();
    return errors + uut.i_sva.fail_cnt;
  endfunction

  // Slave-side AR driver and R checker
  always @(posedge clk_i) begin
    logic              hold;
    logic [DATA_W+1:0] head;
    for (int i = 0; i < NO_SLV_PORTS; i++) begin
      hold = slv_ar_valid_i[i] && !slv_ar_ready_o[i];
      if (slv_ar_valid_i[i] && slv_ar_ready_o[i]) begin
        exp_q[i].push_back(expect_beat(i, slv_ar_addr_i[i]));
        void'(req_q[i].pop_front());
      end
      if (slv_r_valid_o[i] && slv_r_ready_i[i]) begin
        assert (exp_q[i].size() > 0) else begin
          errors++;
          $display("error %0t: slave port %0d returned a beat with no read issued", $time, i);
        end
        if (exp_q[i].size() > 0) begin
          head = exp_q[i].pop_front();
          assert ({slv_r_resp_o[i], slv_r_data_o[i]} == head) else begin
            errors++;
            $display("error %0t: port %0d got resp %0d data %h, expected resp %0d data %h",
                     $time, i, slv_r_resp_o[i], slv_r_data_o[i],
                     head[DATA_W +: 2], head[DATA_W-1:0]);
          end
        end
      end
      if (req_q[i].size() > 0 && (hold || $urandom_range(3, 0) != 0)) begin
        slv_ar_valid_i[i] <= 1'b1;
        slv_ar_addr_i[i]  <= req_q[i][0];
      end else begin
        slv_ar_valid_i[i] <= 1'b0;
      end
      slv_r_ready_i[i] <= !back_pressure || ($urandom_range(1, 0) == 1);
    end
  end

  // Master memory models with random AR and R delays
  always @(posedge clk_i) begin
    logic keep;
    for (int j = 0; j < NO_MST_PORTS; j++) begin
      for (int i = 0; i < NO_SLV_PORTS; i++) begin
        keep = mst_r_valid_i[j][i] && !mst_r_ready_o[j][i];
        if (mst_ar_valid_o[j][i] && mst_ar_ready_i[j][i]) begin
          mst_q[j][i].push_back(mst_ar_addr_o[j][i]);
        end
        if (mst_r_valid_i[j][i] && mst_r_ready_o[j][i]) begin
          void'(mst_q[j][i].pop_front());
        end
        mst_ar_ready_i[j][i] <= ($urandom_range(2, 0) != 0);
        if (mst_q[j][i].size() > 0 && (keep || $urandom_range(1, 0) == 1)) begin
          mst_r_valid_i[j][i] <= 1'b1;
          mst_r_data_i[j][i]  <= (mst_q[j][i][0] ^ 32'hA5A5_0000) + DATA_W'(j);
          mst_r_resp_i[j][i]  <= RESP_OKAY;
        end else begin
          mst_r_valid_i[j][i] <= 1'b0;
        end
      end
    end
  end

  task automatic wait_drained(input string name);
    int cycles;
    cycles = 0;
    while (!aborted &&
           (req_q[0].size() + req_q[1].size() + exp_q[0].size() + exp_q[1].size()) != 0) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("timeout: reads of test %s did not complete", name);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    int errs;
    errs = total_errors() - err_before;
    tests_run++;
    if (aborted || errs != 0) begin
      tests_failed++;
    end
    $display("test %-10s %s (%0d errors)", name, aborted ? "aborted" :
             (errs != 0) ? "failed" : "ok", errs);
  endtask

  task automatic queue_random(input int count);
    addr_t base;
    for (int n = 0; n < count; n++) begin
      for (int i = 0; i < NO_SLV_PORTS; i++) begin
        case ($urandom_range(4, 0))
          0: base = 32'h0000_0000;
          1: base = 32'h0000_1000;
          2: base = 32'h0000_3000;
          3: base = 32'h0000_2000;
          default: base = 32'h0001_0000;
        endcase
        req_q[i].push_back(base + ($urandom_range(32'hfff, 0) & 32'hffc));
      end
    end
  endtask

  initial begin
    int err_before;
    void'($urandom(32'h88c6c146));
    rst_i                 = 1'b1;
    slv_ar_valid_i        = '0;
    slv_ar_addr_i         = '0;
    slv_r_ready_i         = '0;
    mst_ar_ready_i        = '0;
    mst_r_valid_i         = '0;
    mst_r_data_i          = '0;
    en_default_mst_port_i = '0;
    default_mst_port_i    = '0;
    for (int j = 0; j < NO_MST_PORTS; j++) begin
      for (int i = 0; i < NO_SLV_PORTS; i++) begin
        mst_r_resp_i[j][i] = RESP_OKAY;
      end
    end
    addr_map_i[0] = '{idx: 1'b0, start_addr: 32'h0000_0000, end_addr: 32'h0000_1000};
    addr_map_i[1] = '{idx: 1'b1, start_addr: 32'h0000_1000, end_addr: 32'h0000_2000};
    addr_map_i[2] = '{idx: 1'b1, start_addr: 32'h0000_3000, end_addr: 32'h0000_4000};
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;

    // Mapped reads on both slave ports
    err_before = total_errors();
    @(negedge clk_i);
    req_q[0] = '{32'h0000_0010, 32'h0000_1020, 32'h0000_3030, 32'h0000_0ffc};
    req_q[1] = '{32'h0000_1100, 32'h0000_3ffc, 32'h0000_1ffc};
    wait_drained("mapped");
    finish_test("mapped", err_before);

    // Unmapped with no default port
    err_before = total_errors();
    @(negedge clk_i);
    req_q[0] = '{32'h0000_2000, 32'h0000_5000, 32'h0000_0040};
    req_q[1] = '{32'h4000_0000, 32'h0000_1040};
    wait_drained("decerr");
    finish_test("decerr", err_before);

    // Default port per slave port
    err_before = total_errors();
    @(posedge clk_i);
    en_default_mst_port_i <= 2'b11;
    default_mst_port_i    <= 2'b10;
    @(negedge clk_i);
    req_q[0] = '{32'h0000_2000, 32'h0000_0100, 32'h0000_9ff0};
    req_q[1] = '{32'h0000_2004, 32'h0000_1200};
    wait_drained("default");
    finish_test("default", err_before);

    // Slave 1 into master 0's window
    err_before = total_errors();
    @(posedge clk_i);
    en_default_mst_port_i <= 2'b00;
    @(negedge clk_i);
    req_q[1] = '{32'h0000_0100, 32'h0000_0ffc, 32'h0000_1000, 32'h0000_0000};
    wait_drained("unconnect");
    finish_test("unconnect", err_before);

    // Mixed targets under R back-pressure
    err_before = total_errors();
    @(posedge clk_i);
    en_default_mst_port_i <= 2'b01;
    default_mst_port_i    <= 2'b01;
    @(negedge clk_i);
    back_pressure = 1'b1;
    queue_random(60);
    wait_drained("random");
    finish_test("random", err_before);

    $display("summary: %0d tests, %0d failed, %0d errors",
             tests_run, tests_failed, total_errors());
    if (aborted || total_errors() != 0) begin
      $display("TESTBENCH FAILED");
    end else begin
      $display("TESTBENCH PASSED");
    end
    $finish;
  end

endmodule
